//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ray generator testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module ray_gen_tb -f src.f -o ray_gen_sim \
	&& ./obj_dir/ray_gen_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation ended with an error"; exit 1; }

grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- src.f
verilog/ray_pkg.sv
verilog/pixel_stream_if.sv
verilog/ray_pixel_walker.sv
verilog/ray_dir_pipe.sv
verilog/ray_fifo.sv
verilog/ray_gen_top.sv
testbench/ray_gen_properties.sv
testbench/ray_gen_tb.sv

//--- testbench/ray_gen_properties.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_properties (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic ray_valid,
	input logic ray_stall,
	input ray_pkg::ray_t ray_data
);

	// head of the queue holds while the shader side stalls
	stall_holds_data: assert property (@(posedge clk) disable iff (rst)
		ray_valid && ray_stall |=> $stable(ray_data))
		else $error("ray_data changed while ray_valid and ray_stall were high");

	// queue leaves reset empty
	valid_low_after_reset: assert property (@(posedge clk)
		rst |=> !ray_valid)
		else $error("ray_valid high in the cycle after reset");

	busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(start))
		else $error("busy rose without a start pulse");

endmodule

bind ray_gen_top ray_gen_properties props (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.ray_valid(ray_valid),
	.ray_stall(ray_stall),
	.ray_data(ray_data)
);

`default_nettype wire

//--- testbench/ray_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_tb;

	localparam int MAX_SCALE = 3;
	localparam int DIR_STAGES = 3;
	localparam int FIFO_DEPTH = 16;
	localparam int TILE_PIX = ray_pkg::TILE_COLS * ray_pkg::TILE_ROWS;
	// scale 0, scales 1 to 3, random stall at scale 2, long stall at scale 1
	localparam int TOTAL_RAYS = 300 + 1200 + 4800 + 19200 + 4800 + 1200;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_RAYS + 2000;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic [5:0] keys;
	ray_pkg::vec3_t E, U, V, W;
	logic ray_stall;
	logic ray_valid;
	ray_pkg::ray_t ray_data;
	logic [2:0] scale;
	logic busy;

	int cycle_count = 0;
	int rx_count = 0;
	int ray_errors = 0;
	int ray_checks = 0;
	int errors = 0;
	int checks = 0;
	int test_num = 0;
	int test_err_base = 0;
	int frame_scale = 0;
	int frame_total = 0;
	int frame_base = 0;
	int seq_n;
	ray_pkg::ray_t exp_ray;

	ray_gen_top #(
		.MAX_SCALE(MAX_SCALE),
		.DIR_STAGES(DIR_STAGES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.clk(clk),
		.rst(rst),
		.start(start),
		.keys(keys),
		.E(E),
		.U(U),
		.V(V),
		.W(W),
		.ray_stall(ray_stall),
		.ray_valid(ray_valid),
		.ray_data(ray_data),
		.scale(scale),
		.busy(busy)
	);

	always #2 clk = ~clk;

	// tiles in Morton order with tile y counted from the bottom
	function automatic int expected_pixel_id(input int n, input int s);
		int tile, idx, tx, ty, col, row;
		tile = n / TILE_PIX;
		idx = n % TILE_PIX;
		tx = 0;
		ty = 0;
		for (int b = 0; b < 8; b++) begin
			tx = tx | (((tile >> (2 * b)) & 1) << b);
			ty = ty | (((tile >> (2 * b + 1)) & 1) << b);
		end
		col = tx * ray_pkg::TILE_COLS + idx % ray_pkg::TILE_COLS;
		row = ((1 << s) - 1 - ty) * ray_pkg::TILE_ROWS + idx / ray_pkg::TILE_COLS;
		return row * (ray_pkg::TILE_COLS << s) + col;
	endfunction

	function automatic ray_pkg::coord_t dir_component(input int ox, input int oy, input int s,
			input ray_pkg::coord_t uc, input ray_pkg::coord_t vc, input ray_pkg::coord_t wc);
		int sum;
		sum = int'(wc) + ((ox * int'(uc) + oy * int'(vc)) >>> s);
		return sum[15:0];
	endfunction

	function automatic ray_pkg::ray_t expected_ray(input int pid, input int s,
			input ray_pkg::vec3_t e, input ray_pkg::vec3_t u, input ray_pkg::vec3_t v,
			input ray_pkg::vec3_t w);
		int cols, rows, ox, oy;
		ray_pkg::ray_t r;
		cols = ray_pkg::TILE_COLS << s;
		rows = ray_pkg::TILE_ROWS << s;
		ox = pid % cols - cols / 2;
		oy = rows / 2 - pid / cols;
		r.origin = e;
		r.dir.x = dir_component(ox, oy, s, u.x, v.x, w.x);
		r.dir.y = dir_component(ox, oy, s, u.y, v.y, w.y);
		r.dir.z = dir_component(ox, oy, s, u.z, v.z, w.z);
		r.pixel_id = 15'(pid);
		return r;
	endfunction

	// compare every ray that leaves the queue
	always @(posedge clk) begin
		if (!rst && ray_valid && !ray_stall) begin
			seq_n = rx_count - frame_base;
			if (seq_n >= frame_total) begin
				ray_errors++;
				$display("extra ray with pixel id %h arrived after the frame ended",
					ray_data.pixel_id);
			end else begin
				exp_ray = expected_ray(expected_pixel_id(seq_n, frame_scale), frame_scale,
					E, U, V, W);
				ray_checks += 3;
				if (ray_data.pixel_id !== exp_ray.pixel_id) begin
					ray_errors++;
					$display("FAIL ray_data.pixel_id got %h expected %h",
						ray_data.pixel_id, exp_ray.pixel_id);
				end
				if (ray_data.origin !== exp_ray.origin) begin
					ray_errors++;
					$display("FAIL ray_data.origin got %h expected %h",
						ray_data.origin, exp_ray.origin);
				end
				if (ray_data.dir !== exp_ray.dir) begin
					ray_errors++;
					$display("FAIL ray_data.dir got %h expected %h (pixel %h)",
						ray_data.dir, exp_ray.dir, exp_ray.pixel_id);
				end
			end
			rx_count++;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the frames did not complete", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic press_keys(input logic [5:0] k);
		keys = k;
		@(negedge clk);
		keys = 6'd0;
		@(negedge clk);
	endtask

	task automatic randomize_camera();
		E.x = 16'($urandom);
		E.y = 16'($urandom);
		E.z = 16'($urandom);
		U.x = 16'($urandom);
		U.y = 16'($urandom);
		U.z = 16'($urandom);
		V.x = 16'($urandom);
		V.y = 16'($urandom);
		V.z = 16'($urandom);
		W.x = 16'($urandom);
		W.y = 16'($urandom);
		W.z = 16'($urandom);
	endtask

	// mode 0 no stall, 1 random stall, 2 one long stall mid frame
	task automatic run_frame(input int s, input int mode, input logic [5:0] busy_key);
		int cyc;
		int held_at;
		logic held;
		cyc = 0;
		held = 1'b0;
		randomize_camera();
		frame_scale = s;
		frame_total = (ray_pkg::TILE_COLS << s) * (ray_pkg::TILE_ROWS << s);
		frame_base = rx_count;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_value("busy", 32'(busy), 32'd1);
		while (rx_count - frame_base < frame_total) begin
			keys = (cyc == 10) ? busy_key : 6'd0;
			ray_stall = (mode == 1) ? ($urandom % 4 == 0) : 1'b0;
			if (mode == 2 && !held && rx_count - frame_base >= 100) begin
				held = 1'b1;
				ray_stall = 1'b1;
				held_at = rx_count;
				repeat (400) @(negedge clk);
				checks++;
				if (rx_count != held_at) begin
					errors++;
					$display("rays kept leaving the queue while ray_stall was held high");
				end
				check_value("ray_valid", 32'(ray_valid), 32'd1);
				check_value("busy", 32'(busy), 32'd1);
				ray_stall = 1'b0;
			end
			cyc++;
			@(negedge clk);
		end
		ray_stall = 1'b0;
		keys = 6'd0;
		repeat (8) @(negedge clk);
		check_value("busy", 32'(busy), 32'd0);
		check_value("ray_valid", 32'(ray_valid), 32'd0);
		check_value("ray count", 32'(rx_count - frame_base), 32'(frame_total));
		check_value("scale", 32'(scale), 32'(s));
	endtask

	task automatic finish_test(input string name);
		int errs;
		errs = errors + ray_errors - test_err_base;
		test_num++;
		$display("test %0d %s: %0d errors", test_num, name, errs);
		test_err_base = errors + ray_errors;
	endtask

	initial begin
		void'($urandom(32'h21bc));
		rst = 1'b1;
		start = 1'b0;
		keys = 6'd0;
		ray_stall = 1'b0;
		E = '0;
		U = '0;
		V = '0;
		W = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		check_value("scale", 32'(scale), 32'(MAX_SCALE));
		check_value("busy", 32'(busy), 32'd0);
		check_value("ray_valid", 32'(ray_valid), 32'd0);
		finish_test("reset state");

		press_keys(6'b000001);
		check_value("scale", 32'(scale), 32'd0);
		run_frame(0, 0, 6'd0);
		finish_test("scale 0 frame");

		// a key while busy must not disturb the frame
		press_keys(6'b000010);
		check_value("scale", 32'(scale), 32'd1);
		run_frame(1, 0, 6'b000100);
		press_keys(6'b000100);
		check_value("scale", 32'(scale), 32'd2);
		run_frame(2, 0, 6'd0);
		press_keys(6'b001000);
		check_value("scale", 32'(scale), 32'd3);
		run_frame(3, 0, 6'd0);
		press_keys(6'b010000);
		check_value("scale", 32'(scale), 32'd3);
		press_keys(6'b000101);
		check_value("scale", 32'(scale), 32'd3);
		finish_test("scale selection");

		press_keys(6'b000100);
		run_frame(2, 1, 6'd0);
		finish_test("random ray_stall");

		press_keys(6'b000010);
		run_frame(1, 2, 6'd0);
		finish_test("long ray_stall");

		$display("tests: %0d, checks: %0d, errors: %0d, rays: %0d", test_num,
			checks + ray_checks, errors + ray_errors, rx_count);
		if (errors + ray_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/pixel_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pixel_stream_if;

	logic valid;
	logic stall;
	logic [9:0] col;
	logic [9:0] row;
	ray_pkg::pixel_id_t pixel_id;
	logic [2:0] scale;

	// a pixel moves on an edge with valid high and stall low
	modport producer (
		output valid, col, row, pixel_id, scale,
		input stall
	);

	modport consumer (
		input valid, col, row, pixel_id, scale,
		output stall
	);

endinterface

`default_nettype wire

//--- verilog/ray_dir_pipe.sv
`timescale 1ns/10ps
`default_nettype none

module ray_dir_pipe #(
	parameter int DIR_STAGES = 3,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	pixel_stream_if.consumer px,
	input ray_pkg::vec3_t E,
	input ray_pkg::vec3_t U,
	input ray_pkg::vec3_t V,
	input ray_pkg::vec3_t W,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
	output logic wr_en,
	output ray_pkg::ray_t ray
);

	localparam int CW = $clog2(FIFO_DEPTH + 1);
	localparam int XS = DIR_STAGES - 3;
	localparam logic [CW:0] CREDIT_LIMIT = (CW+1)'(FIFO_DEPTH - 1);

	logic accept;
	logic [9:0] half_cols;
	logic [9:0] half_rows;
	logic signed [31:0] off_x;
	logic signed [31:0] off_y;
	logic [CW-1:0] in_flight;
	logic [CW:0] committed;

	logic s1_valid;
	ray_pkg::pixel_id_t s1_pid;
	logic [2:0] s1_scale;
	logic signed [31:0] s1_ux, s1_uy, s1_uz;
	logic signed [31:0] s1_vx, s1_vy, s1_vz;

	logic signed [31:0] sum_x, sum_y, sum_z;
	logic s2_valid;
	ray_pkg::pixel_id_t s2_pid;
	ray_pkg::coord_t s2_dx, s2_dy, s2_dz;

	ray_pkg::ray_t out_ray [XS+1];
	logic [XS:0] out_valid;

	assign accept = px.valid && !px.stall;

	// offsets from the screen centre
	assign half_cols = (10'(ray_pkg::TILE_COLS) << px.scale) >> 1;
	assign half_rows = (10'(ray_pkg::TILE_ROWS) << px.scale) >> 1;
	assign off_x = $signed({22'd0, px.col}) - $signed({22'd0, half_cols});
	assign off_y = $signed({22'd0, half_rows}) - $signed({22'd0, px.row});

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= accept;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_pid <= px.pixel_id;
		s1_scale <= px.scale;
		s1_ux <= off_x * U.x;
		s1_uy <= off_x * U.y;
		s1_uz <= off_x * U.z;
		s1_vx <= off_y * V.x;
		s1_vy <= off_y * V.y;
		s1_vz <= off_y * V.z;
	end

	// pixel pitch is a shift by the scale
	assign sum_x = (s1_ux + s1_vx) >>> s1_scale;
	assign sum_y = (s1_uy + s1_vy) >>> s1_scale;
	assign sum_z = (s1_uz + s1_vz) >>> s1_scale;

	always_ff @(posedge clk) begin
		s2_pid <= s1_pid;
		s2_dx <= sum_x[15:0];
		s2_dy <= sum_y[15:0];
		s2_dz <= sum_z[15:0];
	end

	// low 16 bits of the 32-bit sum
	always_ff @(posedge clk) begin
		out_ray[0].origin <= E;
		out_ray[0].dir.x <= s2_dx + W.x;
		out_ray[0].dir.y <= s2_dy + W.y;
		out_ray[0].dir.z <= s2_dz + W.z;
		out_ray[0].pixel_id <= s2_pid;
		for (int i = 1; i <= XS; i++) begin
			out_ray[i] <= out_ray[i-1];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_valid <= '0;
		end else begin
			out_valid[0] <= s2_valid;
			for (int i = 1; i <= XS; i++) begin
				out_valid[i] <= out_valid[i-1];
			end
		end
	end

	assign wr_en = out_valid[XS];
	assign ray = out_ray[XS];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_flight <= '0;
		end else if (accept && !wr_en) begin
			in_flight <= in_flight + 1'b1;
		end else if (!accept && wr_en) begin
			in_flight <= in_flight - 1'b1;
		end
	end

	// hold the walker when one more ray could overfill the queue
	assign committed = {1'b0, in_flight} + {1'b0, fifo_count};
	assign px.stall = (committed >= CREDIT_LIMIT);

endmodule

`default_nettype wire

//--- verilog/ray_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module ray_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic rd_en,
	input ray_pkg::ray_t din,
	output ray_pkg::ray_t dout,
	output logic empty,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count
);

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	ray_pkg::ray_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = (count == '0);
	assign do_wr = wr_en && (count != CW'(FIFO_DEPTH));
	assign do_rd = rd_en && !empty;

	// head word is visible while not empty
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/ray_gen_top.sv
`timescale 1ns/10ps
`default_nettype none

module ray_gen_top #(
	parameter int MAX_SCALE = 3,
	parameter int DIR_STAGES = 3,
	parameter int FIFO_DEPTH = 16
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [5:0] keys,
	input ray_pkg::vec3_t E,
	input ray_pkg::vec3_t U,
	input ray_pkg::vec3_t V,
	input ray_pkg::vec3_t W,
	input logic ray_stall,
	output logic ray_valid,
	output ray_pkg::ray_t ray_data,
	output logic [2:0] scale,
	output logic busy
);

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	logic wr_en;
	logic rd_en;
	logic fifo_empty;
	logic [CW-1:0] fifo_count;
	ray_pkg::ray_t pipe_ray;

	pixel_stream_if px_if ();

	ray_pixel_walker #(
		.MAX_SCALE(MAX_SCALE)
	) walker (
		.clk(clk),
		.rst(rst),
		.start(start),
		.keys(keys),
		.scale(scale),
		.busy(busy),
		.px(px_if.producer)
	);

	ray_dir_pipe #(
		.DIR_STAGES(DIR_STAGES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dir_pipe (
		.clk(clk),
		.rst(rst),
		.px(px_if.consumer),
		.E(E),
		.U(U),
		.V(V),
		.W(W),
		.fifo_count(fifo_count),
		.wr_en(wr_en),
		.ray(pipe_ray)
	);

	ray_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) queue (
		.clk(clk),
		.rst(rst),
		.wr_en(wr_en),
		.rd_en(rd_en),
		.din(pipe_ray),
		.dout(ray_data),
		.empty(fifo_empty),
		.count(fifo_count)
	);

	// shader side pops whenever it is not stalling
	assign ray_valid = !fifo_empty;
	assign rd_en = ray_valid && !ray_stall;

endmodule

`default_nettype wire

//--- verilog/ray_pixel_walker.sv
`timescale 1ns/10ps
`default_nettype none

module ray_pixel_walker #(
	parameter int MAX_SCALE = 3
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [5:0] keys,
	output logic [2:0] scale,
	output logic busy,
	pixel_stream_if.producer px
);

	localparam int TW = 2 * MAX_SCALE + 1;
	localparam int SW = MAX_SCALE + 1;
	localparam logic [4:0] COL_LAST = 5'(ray_pkg::TILE_COLS - 1);
	localparam logic [3:0] ROW_LAST = 4'(ray_pkg::TILE_ROWS - 1);

	ray_pkg::walker_state_e state;
	logic [2:0] scale_q;
	logic [TW-1:0] tile;
	logic [TW-1:0] last_tile;
	logic [4:0] in_col;
	logic [3:0] in_row;
	logic [SW-1:0] tile_x;
	logic [SW-1:0] tile_y;
	logic [9:0] cols;
	logic [9:0] top_tile;
	logic [9:0] col;
	logic [9:0] row;
	logic [19:0] pid_full;
	logic accept;
	logic tile_done;
	logic frame_done;
	logic key_one_hot;
	logic key_ok;
	logic [2:0] key_idx;

	// only a single key in range selects a scale
	always_comb begin
		key_idx = 3'd0;
		for (int i = 0; i < 6; i++) begin
			if (keys[i]) begin
				key_idx = 3'(i);
			end
		end
	end

	assign key_one_hot = (keys != 6'd0) && ((keys & (keys - 6'd1)) == 6'd0);
	assign key_ok = key_one_hot && (int'(key_idx) <= MAX_SCALE);

	// even bits of the tile counter give x, odd bits give y
	always_comb begin
		tile_x = '0;
		tile_y = '0;
		for (int i = 0; i < MAX_SCALE; i++) begin
			tile_x[i] = tile[2*i];
			tile_y[i] = tile[2*i+1];
		end
	end

	assign cols = 10'(ray_pkg::TILE_COLS) << scale_q;
	assign top_tile = (10'd1 << scale_q) - 10'd1;
	assign last_tile = TW'((32'd1 << (2 * scale_q)) - 32'd1);

	// tile y counts up from the bottom, rows count down from the top
	assign col = 10'(tile_x) * 10'(ray_pkg::TILE_COLS) + 10'(in_col);
	assign row = (top_tile - 10'(tile_y)) * 10'(ray_pkg::TILE_ROWS) + 10'(in_row);
	assign pid_full = {10'd0, row} * {10'd0, cols} + {10'd0, col};

	assign tile_done = (in_col == COL_LAST) && (in_row == ROW_LAST);
	assign frame_done = tile_done && (tile == last_tile);

	assign px.valid = (state == ray_pkg::ACTIVE);
	assign px.col = col;
	assign px.row = row;
	assign px.pixel_id = pid_full[14:0];
	assign px.scale = scale_q;
	assign accept = px.valid && !px.stall;

	assign busy = (state == ray_pkg::ACTIVE);
	assign scale = scale_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ray_pkg::IDLE;
		end else begin
			case (state)
				ray_pkg::IDLE: begin
					if (start) begin
						state <= ray_pkg::ACTIVE;
					end
				end
				ray_pkg::ACTIVE: begin
					if (accept && frame_done) begin
						state <= ray_pkg::IDLE;
					end
				end
				default: state <= ray_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			scale_q <= 3'(MAX_SCALE);
		end else if (state == ray_pkg::IDLE && key_ok) begin
			scale_q <= key_idx;
		end
	end

	// walk left to right, then next row, then next tile
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tile <= '0;
			in_col <= '0;
			in_row <= '0;
		end else if (accept) begin
			if (in_col == COL_LAST) begin
				in_col <= '0;
				if (in_row == ROW_LAST) begin
					in_row <= '0;
					tile <= frame_done ? '0 : tile + 1'b1;
				end else begin
					in_row <= in_row + 1'b1;
				end
			end else begin
				in_col <= in_col + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/ray_pkg.sv
`default_nettype none

package ray_pkg;

	// signed fixed point with one word per component
	typedef logic signed [15:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t z;
	} vec3_t;

	// row-major index with row 0 at the top of the screen
	typedef logic [14:0] pixel_id_t;

	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
		pixel_id_t pixel_id;
	} ray_t;

	// one tile of the Morton walk
	localparam int TILE_COLS = 20;
	localparam int TILE_ROWS = 15;

	typedef enum logic {
		IDLE,
		ACTIVE
	} walker_state_e;

endpackage

`default_nettype wire
